//--- Makefile
VERILATOR ?= verilator
TOP       ?= exu_tb
FLIST     ?= flist.f
VFLAGS    ?= --assert
OBJ_DIR   ?= obj_dir

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
src/rv64_isa_pkg.sv
src/exu_pkg.sv
src/regfile.sv
src/imm_gen.sv
src/alu_ctrl.sv
src/alu.sv
src/exu_top.sv
verification/exu_assertions.sv
verification/exu_tb.sv

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
  input  exu_pkg::word_t   a,
  input  exu_pkg::word_t   b,
  input  exu_pkg::alu_op_e alu_op,
  output exu_pkg::word_t   result
);

  exu_pkg::shamt_t shamt;
  logic [4:0]      shamt_w;
  logic [31:0]     w_res;

  assign shamt   = b[5:0];
  assign shamt_w = b[4:0];

  // low-word result for the W forms
  always_comb begin
    case (alu_op)
      exu_pkg::alu_addw: w_res = a[31:0] + b[31:0];
      exu_pkg::alu_subw: w_res = a[31:0] - b[31:0];
      exu_pkg::alu_sllw: w_res = a[31:0] << shamt_w;
      exu_pkg::alu_srlw: w_res = a[31:0] >> shamt_w;
      exu_pkg::alu_sraw: w_res = $signed(a[31:0]) >>> shamt_w;
      default:           w_res = '0;
    endcase
  end

  always_comb begin
    case (alu_op)
      exu_pkg::alu_add:  result = a + b;
      exu_pkg::alu_sub:  result = a - b;
      exu_pkg::alu_sll:  result = a << shamt;
      exu_pkg::alu_srl:  result = a >> shamt;
      exu_pkg::alu_sra:  result = $signed(a) >>> shamt;
      exu_pkg::alu_xor:  result = a ^ b;
      exu_pkg::alu_or:   result = a | b;
      exu_pkg::alu_and:  result = a & b;
      exu_pkg::alu_slt:  result = exu_pkg::word_t'($signed(a) < $signed(b));
      exu_pkg::alu_sltu: result = exu_pkg::word_t'(a < b);
      exu_pkg::alu_addw,
      exu_pkg::alu_subw,
      exu_pkg::alu_sllw,
      exu_pkg::alu_srlw,
      exu_pkg::alu_sraw: result = {{32{w_res[31]}}, w_res}; // sext bit 31
      exu_pkg::alu_pass_b: result = b;
      exu_pkg::alu_eq:   result = exu_pkg::word_t'(a == b);
      exu_pkg::alu_ne:   result = exu_pkg::word_t'(a != b);
      exu_pkg::alu_lt:   result = exu_pkg::word_t'($signed(a) < $signed(b));
      exu_pkg::alu_ge:   result = exu_pkg::word_t'($signed(a) >= $signed(b));
      exu_pkg::alu_ltu:  result = exu_pkg::word_t'(a < b);
      exu_pkg::alu_geu:  result = exu_pkg::word_t'(a >= b);
      default:           result = '0;
    endcase
  end

endmodule

//--- src/alu_ctrl.sv
`timescale 1ns/1ps

module alu_ctrl (
  input  rv64_isa_pkg::opcode_t opcode,
  input  rv64_isa_pkg::funct3_t funct3,
  input  logic                  funct7_b5,
  output exu_pkg::alu_op_e      alu_op,
  output logic                  op_illegal
);

  always_comb begin
    alu_op     = exu_pkg::alu_add;
    op_illegal = 1'b0;
    case (opcode)
      rv64_isa_pkg::op_r, rv64_isa_pkg::op_i: begin
        case (funct3)
          rv64_isa_pkg::f3_add: begin
            // only the register form has sub
            if (opcode == rv64_isa_pkg::op_r && funct7_b5)
              alu_op = exu_pkg::alu_sub;
            else
              alu_op = exu_pkg::alu_add;
          end
          rv64_isa_pkg::f3_sll:  alu_op = exu_pkg::alu_sll;
          rv64_isa_pkg::f3_slt:  alu_op = exu_pkg::alu_slt;
          rv64_isa_pkg::f3_sltu: alu_op = exu_pkg::alu_sltu;
          rv64_isa_pkg::f3_xor:  alu_op = exu_pkg::alu_xor;
          rv64_isa_pkg::f3_sr:   alu_op = funct7_b5 ? exu_pkg::alu_sra : exu_pkg::alu_srl;
          rv64_isa_pkg::f3_or:   alu_op = exu_pkg::alu_or;
          default:               alu_op = exu_pkg::alu_and;
        endcase
        // register form with funct7 bit 5 set only for sub/sra
        if (opcode == rv64_isa_pkg::op_r && funct7_b5 &&
            funct3 != rv64_isa_pkg::f3_add && funct3 != rv64_isa_pkg::f3_sr)
          op_illegal = 1'b1;
      end
      rv64_isa_pkg::op_r32, rv64_isa_pkg::op_i32: begin
        case (funct3)
          rv64_isa_pkg::f3_add: begin
            if (opcode == rv64_isa_pkg::op_r32 && funct7_b5)
              alu_op = exu_pkg::alu_subw;
            else
              alu_op = exu_pkg::alu_addw;
          end
          rv64_isa_pkg::f3_sll: begin
            alu_op     = exu_pkg::alu_sllw;
            op_illegal = (opcode == rv64_isa_pkg::op_r32) && funct7_b5;
          end
          rv64_isa_pkg::f3_sr: alu_op = funct7_b5 ? exu_pkg::alu_sraw : exu_pkg::alu_srlw;
          default:             op_illegal = 1'b1; // no slt/logic in W group
        endcase
      end
      rv64_isa_pkg::op_lui:   alu_op = exu_pkg::alu_pass_b;
      rv64_isa_pkg::op_auipc,
      rv64_isa_pkg::op_jal,
      rv64_isa_pkg::op_jalr:  alu_op = exu_pkg::alu_add; // target or pc+imm
      rv64_isa_pkg::op_branch: begin
        case (funct3)
          rv64_isa_pkg::f3_beq:  alu_op = exu_pkg::alu_eq;
          rv64_isa_pkg::f3_bne:  alu_op = exu_pkg::alu_ne;
          rv64_isa_pkg::f3_blt:  alu_op = exu_pkg::alu_lt;
          rv64_isa_pkg::f3_bge:  alu_op = exu_pkg::alu_ge;
          rv64_isa_pkg::f3_bltu: alu_op = exu_pkg::alu_ltu;
          rv64_isa_pkg::f3_bgeu: alu_op = exu_pkg::alu_geu;
          default:               op_illegal = 1'b1;
        endcase
      end
      default: op_illegal = 1'b1;
    endcase
  end

endmodule

//--- src/exu_pkg.sv
package exu_pkg;

  localparam int xlen = 64;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [5:0]      shamt_t;

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_addw,   // 32-bit forms, result sign-extended from bit 31
    alu_subw,
    alu_sllw,
    alu_srlw,
    alu_sraw,
    alu_pass_b, // lui
    alu_eq,     // branch conditions give 1 or 0
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu
  } alu_op_e;

endpackage

//--- src/exu_top.sv
`timescale 1ns/1ps

module exu_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 instr_valid,
  input  rv64_isa_pkg::instr_t instr,
  input  exu_pkg::word_t       pc,
  output logic                 wb_valid,
  output exu_pkg::reg_idx_t    wb_rd,
  output exu_pkg::word_t       wb_data,
  output logic                 br_valid,
  output logic                 br_taken,
  output exu_pkg::word_t       next_pc,
  output logic                 illegal
);

  rv64_isa_pkg::opcode_t opcode;
  rv64_isa_pkg::funct3_t funct3;
  exu_pkg::reg_idx_t     rd, rs1_idx, rs2_idx;
  exu_pkg::word_t        rs1_data, rs2_data, imm;
  exu_pkg::word_t        op_a, op_b, alu_result;
  exu_pkg::word_t        pc_plus4, wb_value, target;
  exu_pkg::alu_op_e      alu_op;
  logic                  op_illegal, is_branch, is_jal, is_jalr, legal, rf_we;

  assign opcode  = instr[6:0];
  assign rd      = instr[11:7];
  assign funct3  = instr[14:12];
  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];

  assign is_branch = (opcode == rv64_isa_pkg::op_branch);
  assign is_jal    = (opcode == rv64_isa_pkg::op_jal);
  assign is_jalr   = (opcode == rv64_isa_pkg::op_jalr);

  regfile i_regfile (
    .clk(clk), .rst(rst),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
    .we(rf_we), .waddr(rd), .wdata(wb_value),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  imm_gen i_imm_gen (.instr(instr), .imm(imm));

  alu_ctrl i_alu_ctrl (
    .opcode(opcode), .funct3(funct3), .funct7_b5(instr[30]),
    .alu_op(alu_op), .op_illegal(op_illegal)
  );

  assign op_a = (opcode == rv64_isa_pkg::op_auipc || is_jal) ? pc : rs1_data;
  assign op_b = (opcode == rv64_isa_pkg::op_r || opcode == rv64_isa_pkg::op_r32 || is_branch) ?
                rs2_data : imm;

  alu i_alu (.a(op_a), .b(op_b), .alu_op(alu_op), .result(alu_result));

  assign pc_plus4 = pc + 64'd4;
  assign wb_value = (is_jal || is_jalr) ? pc_plus4 : alu_result; // link address for jumps

  always_comb begin
    if (is_branch)
      target = alu_result[0] ? pc + imm : pc_plus4;
    else if (is_jalr)
      target = {alu_result[63:1], 1'b0};
    else
      target = alu_result; // jal: pc+imm from alu
  end

  assign legal = instr_valid && !op_illegal;
  assign rf_we = legal && !is_branch;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
      wb_rd    <= '0;
      br_valid <= 1'b0;
      br_taken <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      wb_valid <= rf_we;
      br_valid <= legal && (is_branch || is_jal || is_jalr);
      br_taken <= legal && (is_jal || is_jalr || (is_branch && alu_result[0]));
      illegal  <= instr_valid && op_illegal;
      if (instr_valid)
        wb_rd <= rd;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      wb_data <= wb_value;
      next_pc <= target;
    end
  end

endmodule

//--- src/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
  input  rv64_isa_pkg::instr_t instr,
  output exu_pkg::word_t       imm
);

  rv64_isa_pkg::opcode_t opcode;
  rv64_isa_pkg::funct3_t funct3;
  logic                  is_shift;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign is_shift = (funct3 == rv64_isa_pkg::f3_sll) || (funct3 == rv64_isa_pkg::f3_sr);

  always_comb begin
    case (opcode)
      rv64_isa_pkg::op_i,
      rv64_isa_pkg::op_i32: begin
        if (is_shift)
          imm = {58'b0, instr[25:20]}; // shamt only, drop funct7
        else
          imm = {{52{instr[31]}}, instr[31:20]};
      end
      rv64_isa_pkg::op_jalr: imm = {{52{instr[31]}}, instr[31:20]};
      rv64_isa_pkg::op_lui,
      rv64_isa_pkg::op_auipc: imm = {{32{instr[31]}}, instr[31:12], 12'b0};
      rv64_isa_pkg::op_jal: begin
        imm = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      rv64_isa_pkg::op_branch: begin
        imm = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      default: imm = '0; // R-type and unsupported
    endcase
  end

endmodule

//--- src/regfile.sv
`timescale 1ns/1ps

module regfile (
  input  logic              clk,
  input  logic              rst,
  input  exu_pkg::reg_idx_t rs1_idx,
  input  exu_pkg::reg_idx_t rs2_idx,
  input  logic              we,
  input  exu_pkg::reg_idx_t waddr,
  input  exu_pkg::word_t    wdata,
  output exu_pkg::word_t    rs1_data,
  output exu_pkg::word_t    rs2_data
);

  exu_pkg::word_t regs [1:31]; // x0 not stored

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- src/rv64_isa_pkg.sv
package rv64_isa_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;

  // major opcodes, inst[6:0]
  localparam opcode_t op_r      = 7'b0110011; // OP
  localparam opcode_t op_r32    = 7'b0111011; // OP-32
  localparam opcode_t op_i      = 7'b0010011; // OP-IMM
  localparam opcode_t op_i32    = 7'b0011011; // OP-IMM-32
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;

  // funct3 for OP / OP-IMM groups
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101; // srl or sra by funct7 bit 5
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // funct3 for BRANCH
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

endpackage

//--- verification/exu_assertions.sv
`timescale 1ns/1ps

module exu_assertions (
  input logic clk,
  input logic rst,
  input logic instr_valid,
  input logic wb_valid,
  input logic br_valid,
  input logic br_taken,
  input logic illegal
);

  // jumps write back and transfer control, so only these pairs are excluded
  assert property (@(posedge clk) !(illegal && (wb_valid || br_valid)))
    else $error("illegal pulse together with a writeback or branch pulse");

  assert property (@(posedge clk) br_taken |-> br_valid)
    else $error("br_taken high without br_valid");

  assert property (@(posedge clk) rst |=> !wb_valid && !br_valid && !br_taken && !illegal)
    else $error("output pulse right after reset");

  assert property (@(posedge clk) !instr_valid |=> !wb_valid && !br_valid && !illegal)
    else $error("output pulse without an issued instruction");

endmodule

bind exu_top exu_assertions i_exu_assertions (
  .clk(clk), .rst(rst), .instr_valid(instr_valid), .wb_valid(wb_valid),
  .br_valid(br_valid), .br_taken(br_taken), .illegal(illegal)
);

//--- verification/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;

  typedef struct packed {
    logic              wb_valid;
    exu_pkg::reg_idx_t wb_rd;
    exu_pkg::word_t    wb_data;
    logic              br_valid;
    logic              br_taken;
    exu_pkg::word_t    next_pc;
    logic              illegal;
  } exp_t;

  localparam int num_instr = 600;
  localparam int rst_timeout = 20;

  logic                 clk;
  logic                 rst;
  logic                 instr_valid;
  rv64_isa_pkg::instr_t instr;
  exu_pkg::word_t       pc;
  logic                 wb_valid;
  exu_pkg::reg_idx_t    wb_rd;
  exu_pkg::word_t       wb_data;
  logic                 br_valid;
  logic                 br_taken;
  exu_pkg::word_t       next_pc;
  logic                 illegal;

  integer         seed;
  int             errors;
  exu_pkg::word_t mirror [0:31];
  exp_t           pend_e;
  exp_t           chk_e;
  logic           pend_on;
  logic           chk_on;

  exu_top i_dut (
    .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .pc(pc),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .br_valid(br_valid),
    .br_taken(br_taken), .next_pc(next_pc), .illegal(illegal)
  );

  always #50 clk = ~clk;

  function automatic exp_t exp_exec(rv64_isa_pkg::instr_t ins, exu_pkg::word_t cur_pc,
                                    exu_pkg::word_t a, exu_pkg::word_t b);
    exp_t                  e;
    rv64_isa_pkg::opcode_t opc;
    rv64_isa_pkg::funct3_t f3;
    logic                  b5;
    logic                  cond;
    exu_pkg::word_t        imm_i, imm_u, imm_j, imm_b, opb, res;
    logic [31:0]           w;
    opc   = ins[6:0];
    f3    = ins[14:12];
    b5    = ins[30];
    imm_i = {{52{ins[31]}}, ins[31:20]};
    imm_u = {{32{ins[31]}}, ins[31:12], 12'b0};
    imm_j = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_b = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    e = '0;
    e.wb_rd = ins[11:7];
    res = '0;
    cond = 1'b0;
    case (opc)
      rv64_isa_pkg::op_r, rv64_isa_pkg::op_i: begin
        opb = (opc == rv64_isa_pkg::op_r) ? b : imm_i;
        case (f3)
          3'b000:  res = (opc == rv64_isa_pkg::op_r && b5) ? a - opb : a + opb;
          3'b001:  res = a << opb[5:0];
          3'b010:  res = {63'b0, $signed(a) < $signed(opb)};
          3'b011:  res = {63'b0, a < opb};
          3'b100:  res = a ^ opb;
          3'b101: begin
            if (b5)
              res = $signed(a) >>> opb[5:0];
            else
              res = a >> opb[5:0];
          end
          3'b110:  res = a | opb;
          default: res = a & opb;
        endcase
        e.illegal = opc == rv64_isa_pkg::op_r && b5 && f3 != 3'b000 && f3 != 3'b101;
      end
      rv64_isa_pkg::op_r32, rv64_isa_pkg::op_i32: begin
        opb = (opc == rv64_isa_pkg::op_r32) ? b : imm_i;
        w = '0;
        case (f3)
          3'b000:  w = (opc == rv64_isa_pkg::op_r32 && b5) ? a[31:0] - opb[31:0]
                                                          : a[31:0] + opb[31:0];
          3'b001:  w = a[31:0] << opb[4:0];
          3'b101: begin
            if (b5)
              w = $signed(a[31:0]) >>> opb[4:0];
            else
              w = a[31:0] >> opb[4:0];
          end
          default: e.illegal = 1'b1;
        endcase
        if (f3 == 3'b001 && opc == rv64_isa_pkg::op_r32 && b5)
          e.illegal = 1'b1;
        res = {{32{w[31]}}, w};
      end
      rv64_isa_pkg::op_lui:   res = imm_u;
      rv64_isa_pkg::op_auipc: res = cur_pc + imm_u;
      rv64_isa_pkg::op_jal: begin
        res = cur_pc + 4;
        e.br_valid = 1'b1;
        e.br_taken = 1'b1;
        e.next_pc  = cur_pc + imm_j;
      end
      rv64_isa_pkg::op_jalr: begin
        res = cur_pc + 4;
        e.br_valid = 1'b1;
        e.br_taken = 1'b1;
        e.next_pc  = (a + imm_i) & ~64'd1; // lsb dropped
      end
      rv64_isa_pkg::op_branch: begin
        case (f3)
          3'b000:  cond = a == b;
          3'b001:  cond = a != b;
          3'b100:  cond = $signed(a) < $signed(b);
          3'b101:  cond = $signed(a) >= $signed(b);
          3'b110:  cond = a < b;
          3'b111:  cond = a >= b;
          default: e.illegal = 1'b1;
        endcase
        e.br_valid = 1'b1;
        e.br_taken = cond;
        e.next_pc  = cond ? cur_pc + imm_b : cur_pc + 4;
      end
      default: e.illegal = 1'b1;
    endcase
    e.wb_data  = res;
    e.wb_valid = !e.illegal && opc != rv64_isa_pkg::op_branch;
    if (e.illegal) begin
      e.br_valid = 1'b0;
      e.br_taken = 1'b0;
    end
    return e;
  endfunction

  task automatic gen_instr(output rv64_isa_pkg::instr_t ins);
    logic [31:0]           r;
    logic [31:0]           s;
    rv64_isa_pkg::opcode_t opc;
    rv64_isa_pkg::funct3_t f3;
    logic [11:0]           imm;
    logic [14:0]           regs; // rs2, rs1, rd
    r = $random(seed);
    s = $random(seed);
    regs = {2'b0, s[2:0], 2'b0, s[5:3], 2'b0, s[8:6]}; // small range for dependencies
    f3 = s[11:9];
    case (r[3:0] % 12)
      0, 10: ins = {1'b0, (f3 == 3'b000 || f3 == 3'b101) & s[12], 5'b0, regs[14:10],
                    regs[9:5], f3, regs[4:0], rv64_isa_pkg::op_r};
      1, 11: begin
        if (f3 == 3'b001)
          imm = {6'b0, r[25:20]};
        else if (f3 == 3'b101)
          imm = {1'b0, s[12], 4'b0, r[25:20]};
        else
          imm = r[31:20];
        ins = {imm, regs[9:5], f3, regs[4:0], rv64_isa_pkg::op_i};
      end
      2: begin
        f3 = (s[10:9] == 2'b00) ? 3'b000 : (s[10:9] == 2'b01) ? 3'b001 : 3'b101;
        ins = {1'b0, (f3 != 3'b001) & s[12], 5'b0, regs[14:10], regs[9:5], f3, regs[4:0],
               rv64_isa_pkg::op_r32};
      end
      3: begin
        f3 = (s[10:9] == 2'b00) ? 3'b000 : (s[10:9] == 2'b01) ? 3'b001 : 3'b101;
        imm = (f3 == 3'b000) ? r[31:20] : {1'b0, (f3 == 3'b101) & s[12], 5'b0, r[24:20]};
        ins = {imm, regs[9:5], f3, regs[4:0], rv64_isa_pkg::op_i32};
      end
      4: ins = {r[31:12], regs[4:0], rv64_isa_pkg::op_lui};
      5: ins = {r[31:12], regs[4:0], rv64_isa_pkg::op_auipc};
      6: ins = {r[31:12], regs[4:0], rv64_isa_pkg::op_jal};
      7: ins = {r[31:20], regs[9:5], 3'b000, regs[4:0], rv64_isa_pkg::op_jalr};
      8: begin
        if (f3 == 3'b010 || f3 == 3'b011)
          f3 = {1'b1, f3[1:0]};
        ins = {r[31:25], regs[14:10], regs[9:5], f3, r[11:7], rv64_isa_pkg::op_branch};
      end
      default: begin
        case (s[14:13])
          2'b00:   opc = 7'b0000011; // load
          2'b01:   opc = 7'b0100011; // store
          2'b10:   opc = 7'b1110011; // system
          default: opc = 7'b0001111; // fence
        endcase
        ins = {r[31:7], opc};
        if (s[15])
          ins = {r[31:25], regs[14:10], regs[9:5], 3'b010, r[11:7], rv64_isa_pkg::op_branch};
      end
    endcase
  endtask

  task automatic check_word(string what, exu_pkg::word_t act, exu_pkg::word_t exp);
    if (act !== exp) begin
      $display("Error: %0t ns: %s is %h, expected %h", $time, what, act, exp);
      errors++;
    end
  endtask

  task automatic check_idx(string what, exu_pkg::reg_idx_t act, exu_pkg::reg_idx_t exp);
    if (act !== exp) begin
      $display("Error: %0t ns: %s is %0d, expected %0d", $time, what, act, exp);
      errors++;
    end
  endtask

  task automatic check_bit(string what, logic act, logic exp);
    if (act !== exp) begin
      $display("Error: %0t ns: %s is %b, expected %b", $time, what, act, exp);
      errors++;
    end
  endtask

  function automatic logic outputs_idle();
    return wb_valid === 1'b0 && br_valid === 1'b0 && br_taken === 1'b0 &&
           illegal === 1'b0 && wb_rd === '0;
  endfunction

  // outputs of the instruction issued before the previous edge
  always @(posedge clk) begin
    if (chk_on) begin
      check_bit("wb_valid", wb_valid, chk_e.wb_valid);
      check_bit("br_valid", br_valid, chk_e.br_valid);
      check_bit("br_taken", br_taken, chk_e.br_taken);
      check_bit("illegal", illegal, chk_e.illegal);
      if (chk_e.wb_valid) begin
        check_idx("wb_rd", wb_rd, chk_e.wb_rd);
        check_word("wb_data", wb_data, chk_e.wb_data);
      end
      if (chk_e.br_valid)
        check_word("next_pc", next_pc, chk_e.next_pc);
    end
    chk_on = pend_on;
    chk_e  = pend_e;
  end

  initial begin
    rv64_isa_pkg::instr_t ins;
    exu_pkg::word_t       cur_pc;
    exp_t                 e;
    int                   wait_cnt;
    clk = 1'b0;
    rst = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    pc = '0;
    seed = 62048;
    errors = 0;
    pend_on = 1'b0;
    pend_e = '0;
    chk_on = 1'b0;
    chk_e = '0;
    for (int i = 0; i < 32; i++)
      mirror[i] = '0;
    repeat (8) @(negedge clk);
    wait_cnt = 0;
    while (!outputs_idle() && wait_cnt < rst_timeout) begin // reset state of the outputs
      @(negedge clk);
      wait_cnt++;
    end
    if (!outputs_idle()) begin
      $display("Timeout: outputs never reached their reset values");
      $display("STATUS: FAIL");
      $finish;
    end else begin
      rst = 1'b0;
      pend_on = 1'b1; // first idle cycle checks reset values
      for (int n = 0; n < num_instr; n++) begin
        @(negedge clk);
        gen_instr(ins);
        cur_pc = {$random(seed), $random(seed)} & ~64'd3;
        if (($random(seed) & 7) == 0) begin
          instr_valid = 1'b0;
          pend_e = '0;
        end else begin
          e = exp_exec(ins, cur_pc, mirror[ins[19:15]], mirror[ins[24:20]]);
          if (e.wb_valid && e.wb_rd != 0)
            mirror[e.wb_rd] = e.wb_data;
          instr_valid = 1'b1;
          pend_e = e;
        end
        instr = ins;
        pc = cur_pc;
      end
      @(negedge clk);
      instr_valid = 1'b0;
      pend_e = '0;
      repeat (3) @(negedge clk);
      $display("errors: %0d", errors);
      if (errors == 0)
        $display("STATUS: PASS");
      else
        $display("STATUS: FAIL");
      $finish;
    end
  end

endmodule
